// ==== Bender.yml ====
package:
  name: conv_accel

sources:
  - files:
      - src/conv_pkg.sv
      - src/conv_input_mems.sv
      - src/conv_sequencer.sv
      - src/conv_mac.sv
      - src/conv_out_fifo.sv
      - src/conv_top.sv
  - target: test
    files:
      - bench/conv_props.sv
      - bench/conv_tb.sv

// ==== bench/conv_props.sv ====
// conv_props: stream protocol, reset state and job hand-off assertions, bound to conv_top
`timescale 1ns/1ps

module conv_props import conv_pkg::*; #(
    parameter int  INW  = 12,
    parameter int  R    = 9,
    parameter int  C    = 8,
    parameter int  MAXK = 5,
    localparam int KW   = k_bits(MAXK),
    localparam int OUTW = out_width(INW, MAXK)
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   INPUT_TVALID,
    input logic                   INPUT_TREADY,
    input logic signed [OUTW-1:0] OUTPUT_TDATA,
    input logic                   OUTPUT_TVALID,
    input logic                   OUTPUT_TREADY,
    input logic                   result_valid,
    input logic [KW-1:0]          k
);

    logic ready_q;
    int   job_results;    // results written since the current job blocked the input
    int   failures = 0;   // assertion failures so far

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q     <= 1'b1;
            job_results <= 0;
        end else begin
            ready_q <= INPUT_TREADY;
            if (INPUT_TREADY && !ready_q)
                job_results <= 0;  // job handed off, start over
            else if (result_valid)
                job_results <= job_results + 1;
        end
    end

    // quiet outputs during and right after reset
    a_reset_state: assert property (@(posedge clk)
        $past(reset) |-> !OUTPUT_TVALID && INPUT_TREADY)
        else begin
            $error("output valid or input blocked right after reset");
            failures++;
        end

    // a stalled word holds
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        OUTPUT_TVALID && !OUTPUT_TREADY |=> OUTPUT_TVALID && $stable(OUTPUT_TDATA))
        else begin
            $error("output word changed while stalled");
            failures++;
        end

    // input only closes right after an accepted word
    a_in_block: assert property (@(posedge clk) disable iff (reset)
        $fell(INPUT_TREADY) |-> $past(INPUT_TVALID))
        else begin
            $error("input ready fell without a transfer");
            failures++;
        end

    // input reopens only once every pixel of the job reached the fifo
    a_job_done: assert property (@(posedge clk) disable iff (reset)
        $rose(INPUT_TREADY) |-> job_results == (R - k + 1) * (C - k + 1))
        else begin
            $error("input reopened before all pixels of the job were written");
            failures++;
        end

endmodule

bind conv_top conv_props #(.INW(INW), .R(R), .C(C), .MAXK(MAXK)) i_conv_props (
    .clk(clk),
    .reset(reset),
    .INPUT_TVALID(INPUT_TVALID),
    .INPUT_TREADY(INPUT_TREADY),
    .OUTPUT_TDATA(OUTPUT_TDATA),
    .OUTPUT_TVALID(OUTPUT_TVALID),
    .OUTPUT_TREADY(OUTPUT_TREADY),
    .result_valid(result_valid),
    .k(k)
);

// ==== bench/conv_tb.sv ====
// conv_tb: clock, reset, lfsr stimulus, golden model, output checks, watchdog and report
`timescale 1ns/1ps

module conv_tb import conv_pkg::*;;

    localparam int INW        = 12;
    localparam int R          = 9;
    localparam int C          = 8;
    localparam int MAXK       = 5;
    localparam int FIFO_DEPTH = 16;
    localparam int KW         = k_bits(MAXK);
    localparam int OUTW       = out_width(INW, MAXK);
    localparam int NT         = 5;                        // number of jobs

    string test_name [NT] = '{"basic_k3", "k1_bias", "kmax_negative", "backpressure", "isolation"};
    int    test_k    [NT] = '{3, 1, MAXK, 2, 3};
    bit    test_neg  [NT] = '{0, 0, 1, 0, 0};            // all samples at the most negative value
    bit    test_bp   [NT] = '{0, 0, 0, 1, 1};            // random output ready
    int    test_left [NT] = '{default: 0};               // pixels still to arrive
    int    test_err  [NT] = '{default: 0};

    logic                   clk = 1'b0;
    logic                   reset;
    logic signed [INW-1:0]  INPUT_TDATA;
    logic [KW-1:0]          INPUT_TUSER;
    logic                   INPUT_TVALID;
    logic                   INPUT_TREADY;
    logic signed [OUTW-1:0] OUTPUT_TDATA;
    logic                   OUTPUT_TVALID;
    logic                   OUTPUT_TREADY;

    logic [31:0] lfsr;
    longint      exp_q [$];  // expected pixels, oldest first
    int          id_q [$];   // job index of each expected pixel
    int          errors     = 0;
    int          checks     = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;

    conv_top #(.INW(INW), .R(R), .C(C), .MAXK(MAXK), .FIFO_DEPTH(FIFO_DEPTH)) i_conv_top (
        .clk, .reset,
        .INPUT_TDATA, .INPUT_TUSER, .INPUT_TVALID, .INPUT_TREADY,
        .OUTPUT_TDATA, .OUTPUT_TVALID, .OUTPUT_TREADY
    );

    always #4 clk = ~clk;  // 8 ns period

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic signed [INW-1:0] sample(input bit neg);
        if (neg)
            return {1'b1, {(INW-1){1'b0}}};
        return INW'(rand_bits(INW));
    endfunction

    // one stream word, with an idle cycle in front now and then
    task automatic send_word(input logic signed [INW-1:0] d, input logic [KW-1:0] u);
        logic taken;
        if (rand_bits(2) == 0) begin
            INPUT_TVALID = 1'b0;
            @(posedge clk);
            #1;
        end
        INPUT_TDATA  = d;
        INPUT_TUSER  = u;
        INPUT_TVALID = 1'b1;
        do begin
            taken = INPUT_TREADY;  // settled mid-cycle
            @(posedge clk);
            #1;
        end while (!taken);
    endtask

    // build a job, queue its golden pixels, then stream it in
    task automatic run_job(input int t);
        int                    kk;
        longint                acc;
        logic signed [INW-1:0] w [MAXK*MAXK];
        logic signed [INW-1:0] x [R*C];
        logic signed [INW-1:0] b;
        kk = test_k[t];
        for (int n = 0; n < kk * kk; n++)
            w[n] = sample(test_neg[t]);
        b = sample(test_neg[t]);
        for (int n = 0; n < R * C; n++)
            x[n] = sample(test_neg[t]);
        test_left[t] = (R - kk + 1) * (C - kk + 1);
        for (int r = 0; r <= R - kk; r++) begin
            for (int c = 0; c <= C - kk; c++) begin
                acc = b;  // bias plus the window dot product
                for (int i = 0; i < kk; i++)
                    for (int j = 0; j < kk; j++)
                        acc += longint'(x[(r + i) * C + c + j]) * longint'(w[i * kk + j]);
                exp_q.push_back(acc);
                id_q.push_back(t);
            end
        end
        send_word(sample(test_neg[t]), KW'(kk));  // k word, data ignored
        for (int n = 0; n < kk * kk; n++)
            send_word(w[n], '0);
        send_word(b, '0);
        for (int n = 0; n < R * C; n++)
            send_word(x[n], '0);
    endtask

    // consumer, throttled while a back-pressure job is at the head
    always @(posedge clk) begin
        #2;
        if (id_q.size() != 0 && test_bp[id_q[0]])
            OUTPUT_TREADY = (rand_bits(2) == 0);  // mostly stalled
        else
            OUTPUT_TREADY = 1'b1;
    end

    // every output transfer against the head of the golden queue
    always @(posedge clk) begin
        int     t;
        longint e;
        if (!reset && OUTPUT_TVALID && OUTPUT_TREADY) begin
            if (exp_q.size() == 0) begin
                $display("output word %0d arrived with no pixel expected", OUTPUT_TDATA);
                errors++;
            end else begin
                t = id_q.pop_front();
                e = exp_q.pop_front();
                checks++;
                assert (OUTPUT_TDATA == e) else begin
                    $display("error %s expected %0d actual %0d", test_name[t], e, OUTPUT_TDATA);
                    errors++;
                    test_err[t]++;
                end
                test_left[t]--;
                if (test_left[t] == 0) begin
                    $display("test %s done, %0d errors", test_name[t], test_err[t]);
                    if (test_err[t] == 0)
                        tests_pass++;
                    else
                        tests_fail++;
                end
            end
        end
    end

    // watchdog sized from input words plus mac taps and outputs of every job
    initial begin
        int budget;
        int kk;
        budget = 200;
        for (int t = 0; t < NT; t++) begin
            kk = test_k[t];
            budget += 8 * (kk * kk + 2 + R * C + (R - kk + 1) * (C - kk + 1) * (kk * kk + 1));
        end
        repeat (budget) @(posedge clk);
        $display("timeout, outputs still missing after %0d cycles", budget);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        INPUT_TDATA   = '0;
        INPUT_TUSER   = '0;
        INPUT_TVALID  = 1'b0;
        OUTPUT_TREADY = 1'b1;
        lfsr          = 32'h2832_107e;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int t = 0; t < NT; t++)
            run_job(t);  // jobs back to back
        INPUT_TVALID = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);  // room for stray words
        $display("%0d tests passed, %0d failed, %0d words, %0d errors, %0d protocol errors",
                 tests_pass, tests_fail, checks, errors, i_conv_top.i_conv_props.failures);
        if (errors == 0 && tests_pass == NT && i_conv_top.i_conv_props.failures == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== src/conv_input_mems.sv ====
// conv_input_mems: job loader with k, weight, bias and image storage and registered read ports
`timescale 1ns/1ps

module conv_input_mems import conv_pkg::*; #(
    parameter int  INW  = 12,
    parameter int  R    = 9,
    parameter int  C    = 8,
    parameter int  MAXK = 5,
    localparam int KW   = k_bits(MAXK),
    localparam int XAW  = $clog2(R * C),
    localparam int WAW  = $clog2(MAXK * MAXK)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic signed [INW-1:0] INPUT_TDATA,
    input  logic [KW-1:0]         INPUT_TUSER,   // kernel size, sampled on the first word
    input  logic                  INPUT_TVALID,
    output logic                  INPUT_TREADY,
    input  logic                  job_release,   // pulse from the sequencer, job consumed
    output logic                  loaded,        // whole job is in memory
    output logic [KW-1:0]         k,
    input  logic [XAW-1:0]        x_addr,
    input  logic [WAW-1:0]        w_addr,
    output logic signed [INW-1:0] x_data,
    output logic signed [INW-1:0] w_data,
    output logic signed [INW-1:0] bias
);

    // load phases, in stream order
    localparam logic [1:0] PH_K = 2'd0;
    localparam logic [1:0] PH_W = 2'd1;
    localparam logic [1:0] PH_B = 2'd2;
    localparam logic [1:0] PH_X = 2'd3;

    // one counter serves both weights and pixels, sized for the larger
    localparam int CNTW = $clog2(((R * C > MAXK * MAXK) ? R * C : MAXK * MAXK) + 1);

    logic [1:0]            phase;
    logic [CNTW-1:0]       cnt;                // word index inside the current phase
    logic [2*KW-1:0]       k_sq;               // number of weights in this job
    logic signed [INW-1:0] w_mem [MAXK*MAXK];  // row-major kernel
    logic signed [INW-1:0] x_mem [R*C];        // row-major image
    logic                  accept;
    logic                  w_done;
    logic                  x_done;

    assign INPUT_TREADY = !loaded;                // blocked while a job is held
    assign accept       = INPUT_TVALID && INPUT_TREADY;
    assign w_done       = (cnt == CNTW'(k_sq) - CNTW'(1));  // last weight word
    assign x_done       = (cnt == CNTW'(R * C - 1));        // last pixel word

    // phase walk and job hand-off
    always_ff @(posedge clk) begin
        if (reset) begin
            phase  <= PH_K;
            cnt    <= '0;
            loaded <= 1'b0;
        end else begin
            if (job_release)
                loaded <= 1'b0;  // ready comes back with it
            if (accept) begin
                case (phase)
                    PH_K: begin
                        phase <= PH_W;
                        cnt   <= '0;
                    end
                    PH_W: begin
                        if (w_done) begin
                            phase <= PH_B;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    PH_B: phase <= PH_X;  // single bias word
                    PH_X: begin
                        if (x_done) begin
                            phase  <= PH_K;  // next word opens a new job
                            cnt    <= '0;
                            loaded <= 1'b1;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // storage writes and read ports
    always_ff @(posedge clk) begin
        if (accept) begin
            case (phase)
                PH_K: begin
                    k    <= INPUT_TUSER;
                    k_sq <= INPUT_TUSER * INPUT_TUSER;
                end
                PH_W:    w_mem[cnt[WAW-1:0]] <= INPUT_TDATA;
                PH_B:    bias <= INPUT_TDATA;
                PH_X:    x_mem[cnt[XAW-1:0]] <= INPUT_TDATA;
            endcase
        end
        x_data <= x_mem[x_addr];  // data one cycle after the address
        w_data <= w_mem[w_addr];
    end

endmodule

// ==== src/conv_mac.sv ====
// conv_mac: two-stage signed multiplier, tap marker delay line and bias-seeded accumulator
`timescale 1ns/1ps

module conv_mac import conv_pkg::*; #(
    parameter int  INW  = 12,
    parameter int  MAXK = 5,
    localparam int OUTW = out_width(INW, MAXK)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic signed [INW-1:0]  x_data,
    input  logic signed [INW-1:0]  w_data,
    input  logic signed [INW-1:0]  bias,
    input  logic                   tap_valid,
    input  logic                   tap_first,
    input  logic                   tap_last,
    output logic signed [OUTW-1:0] result,
    output logic                   result_valid
);

    // markers travel with the read and then the multiplier
    localparam int DLY = read_latency + mult_stages;

    logic signed [2*INW-1:0] prod [mult_stages];  // multiplier pipe, last entry is aligned
    logic [DLY-1:0]          v_dly;
    logic [DLY-1:0]          f_dly;
    logic [DLY-1:0]          l_dly;
    logic signed [OUTW-1:0]  acc;
    logic signed [OUTW-1:0]  acc_next;
    logic signed [OUTW-1:0]  prod_ext;
    logic signed [OUTW-1:0]  bias_ext;

    assign prod_ext = OUTW'(prod[mult_stages-1]);  // sign extended
    assign bias_ext = OUTW'(bias);
    // first tap of a pixel restarts from the bias
    assign acc_next = (f_dly[DLY-1] ? bias_ext : acc) + prod_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            v_dly        <= '0;
            f_dly        <= '0;
            l_dly        <= '0;
            result_valid <= 1'b0;
        end else begin
            v_dly        <= {v_dly[DLY-2:0], tap_valid};
            f_dly        <= {f_dly[DLY-2:0], tap_first};
            l_dly        <= {l_dly[DLY-2:0], tap_last};
            result_valid <= l_dly[DLY-1];  // one pulse per pixel
        end
    end

    always_ff @(posedge clk) begin
        prod[0] <= x_data * w_data;
        for (int s = 1; s < mult_stages; s++)
            prod[s] <= prod[s-1];
        if (v_dly[DLY-1])
            acc <= acc_next;
        if (l_dly[DLY-1])
            result <= acc_next;  // held while the next pixel accumulates
    end

endmodule

// ==== src/conv_out_fifo.sv ====
// conv_out_fifo: result FIFO with occupancy-based room flag and registered output stream stage
`timescale 1ns/1ps

module conv_out_fifo import conv_pkg::*; #(
    parameter int  INW        = 12,
    parameter int  MAXK       = 5,
    parameter int  FIFO_DEPTH = 16,
    localparam int OUTW       = out_width(INW, MAXK)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic signed [OUTW-1:0] result,
    input  logic                   result_valid,
    output logic                   room,
    output logic signed [OUTW-1:0] OUTPUT_TDATA,
    output logic                   OUTPUT_TVALID,
    input  logic                   OUTPUT_TREADY
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int NW = $clog2(FIFO_DEPTH + 2);

    logic signed [OUTW-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [NW-1:0]          count;     // entries in mem, output stage not included
    logic                   out_load;  // output stage may take a new word
    logic                   mem_rd;
    logic                   mem_wr;
    logic                   bypass;    // empty fifo, result goes straight to the output stage

    assign out_load = !OUTPUT_TVALID || OUTPUT_TREADY;
    assign mem_rd   = out_load && (count != '0);
    assign bypass   = out_load && (count == '0) && result_valid;
    assign mem_wr   = result_valid && !bypass;
    // an incoming result already counts against the free space
    assign room     = (count + NW'(result_valid)) <= NW'(FIFO_DEPTH - fifo_reserve);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            OUTPUT_TVALID <= 1'b0;
        end else begin
            if (mem_wr)
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (mem_rd)
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + NW'(mem_wr) - NW'(mem_rd);
            if (out_load)
                OUTPUT_TVALID <= mem_rd || bypass;  // holds while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr)
            mem[wr_ptr] <= result;
        if (mem_rd)
            OUTPUT_TDATA <= mem[rd_ptr];
        else if (bypass)
            OUTPUT_TDATA <= result;
    end

endmodule

// ==== src/conv_pkg.sv ====
// conv_pkg: pipeline latency constants and width helper functions for the convolution core
package conv_pkg;

    localparam int read_latency = 1;  // registered memory read port
    localparam int mult_stages  = 2;  // pipelined multiplier depth

    // last tap address to result pulse: read, multiply, then one accumulate stage
    localparam int mac_latency  = read_latency + mult_stages + 1;

    // free fifo slots needed before a pixel may start
    localparam int fifo_reserve = mac_latency + 1;

    // bits to hold a kernel size in 0..maxk
    function automatic int k_bits(input int maxk);
        return $clog2(maxk + 1);
    endfunction

    // accumulator width
    // worst case is maxk^2 products of two most-negative samples plus the bias,
    // then one more bit for the sign
    function automatic int out_width(input int inw, input int maxk);
        longint unsigned prod_max;  // (-2^(inw-1))^2
        longint unsigned sum_max;   // largest magnitude the accumulator can reach
        prod_max = longint'(1) << (2 * inw - 2);
        sum_max  = longint'(maxk) * longint'(maxk) * prod_max;
        sum_max  = sum_max + (longint'(1) << (inw - 1));  // bias magnitude on top
        return $clog2(sum_max + 1) + 1;
    endfunction

endpackage

// ==== src/conv_sequencer.sv ====
// conv_sequencer: output pixel and kernel tap walker with read addressing, tap markers and job release
`timescale 1ns/1ps

module conv_sequencer import conv_pkg::*; #(
    parameter int  R    = 9,
    parameter int  C    = 8,
    parameter int  MAXK = 5,
    localparam int KW   = k_bits(MAXK),
    localparam int XAW  = $clog2(R * C),
    localparam int WAW  = $clog2(MAXK * MAXK)
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           loaded,
    input  logic [KW-1:0]  k,
    input  logic           room,         // fifo can take a full pixel pipeline
    output logic           job_release,
    output logic           tap_valid,
    output logic           tap_first,
    output logic           tap_last,
    output logic [XAW-1:0] x_addr,
    output logic [WAW-1:0] w_addr
);

    localparam int RW  = $clog2(R + 1);
    localparam int CLW = $clog2(C + 1);
    localparam int DW  = $clog2(mac_latency + 1);

    logic           running;     // job picked up
    logic           all_issued;  // every tap of the job has gone out
    logic [RW-1:0]  r;           // output row
    logic [CLW-1:0] c;           // output column
    logic [KW-1:0]  i;           // kernel row
    logic [KW-1:0]  j;           // kernel column
    logic [XAW-1:0] pix_base;    // image address of tap (0,0) for pixel r,c
    logic [XAW-1:0] next_base;
    logic [XAW-1:0] start_base;
    logic [XAW-1:0] row_jump;    // from end of one kernel row to start of the next
    logic [DW-1:0]  drain;       // counts down the mac pipeline after the last tap
    logic [KW-1:0]  k_m1;
    logic           row_end;
    logic           c_wrap;
    logic           pix_last;
    logic           start_pix;

    assign k_m1      = k - 1'b1;
    assign row_end   = (j == k_m1);
    assign tap_first = tap_valid && (i == '0) && (j == '0);
    assign tap_last  = tap_valid && (i == k_m1) && row_end;
    assign c_wrap    = (c == CLW'(C) - CLW'(k));              // c == C-K
    assign pix_last  = c_wrap && (r == RW'(R) - RW'(k));       // bottom-right pixel
    assign row_jump  = XAW'(C) - XAW'(k) + 1'b1;
    // moving right is +1, wrapping to the next output row skips k-1 columns more
    assign next_base = c_wrap ? pix_base + XAW'(k) : pix_base + 1'b1;
    assign start_base = tap_valid ? next_base : pix_base;
    // a pixel starts from idle, or right behind the last tap of the one before
    assign start_pix = running && !all_issued && room && (!tap_valid || (tap_last && !pix_last));
    assign job_release = all_issued && (drain == DW'(1));  // last result reaches the fifo now

    always_ff @(posedge clk) begin
        if (reset) begin
            running    <= 1'b0;
            all_issued <= 1'b0;
            tap_valid  <= 1'b0;
            drain      <= '0;
            r          <= '0;
            c          <= '0;
            i          <= '0;
            j          <= '0;
            pix_base   <= '0;
            x_addr     <= '0;
            w_addr     <= '0;
        end else if (!loaded) begin
            running    <= 1'b0;  // wait for the next job
            all_issued <= 1'b0;
            tap_valid  <= 1'b0;
            drain      <= '0;
        end else if (!running) begin
            running  <= 1'b1;
            r        <= '0;
            c        <= '0;
            pix_base <= '0;
        end else begin
            if (drain != '0)
                drain <= drain - 1'b1;
            if (tap_valid && !tap_last) begin
                w_addr <= w_addr + 1'b1;  // weights are contiguous
                if (row_end) begin
                    j      <= '0;
                    i      <= i + 1'b1;
                    x_addr <= x_addr + row_jump;
                end else begin
                    j      <= j + 1'b1;
                    x_addr <= x_addr + 1'b1;
                end
            end else begin
                if (tap_last) begin
                    if (pix_last) begin
                        all_issued <= 1'b1;
                        drain      <= DW'(mac_latency);
                    end else begin
                        pix_base <= next_base;
                        if (c_wrap) begin
                            c <= '0;
                            r <= r + 1'b1;
                        end else begin
                            c <= c + 1'b1;
                        end
                    end
                end
                tap_valid <= start_pix;  // gap here only when room is low
                if (start_pix) begin
                    x_addr <= start_base;
                    w_addr <= '0;
                    i      <= '0;
                    j      <= '0;
                end
            end
        end
    end

endmodule

// ==== src/conv_top.sv ====
// conv_top: convolution accelerator with input loader, tap sequencer, mac pipeline and output fifo
`timescale 1ns/1ps

module conv_top #(
    parameter int  INW        = 12,
    parameter int  R          = 9,
    parameter int  C          = 8,
    parameter int  MAXK       = 5,
    parameter int  FIFO_DEPTH = 16,
    localparam int KW         = conv_pkg::k_bits(MAXK),
    localparam int OUTW       = conv_pkg::out_width(INW, MAXK),
    localparam int XAW        = $clog2(R * C),
    localparam int WAW        = $clog2(MAXK * MAXK)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic signed [INW-1:0]  INPUT_TDATA,
    input  logic [KW-1:0]          INPUT_TUSER,
    input  logic                   INPUT_TVALID,
    output logic                   INPUT_TREADY,
    output logic signed [OUTW-1:0] OUTPUT_TDATA,
    output logic                   OUTPUT_TVALID,
    input  logic                   OUTPUT_TREADY
);

    logic                   loaded;
    logic                   job_release;
    logic [KW-1:0]          k;
    logic [XAW-1:0]         x_addr;
    logic [WAW-1:0]         w_addr;
    logic signed [INW-1:0]  x_data;
    logic signed [INW-1:0]  w_data;
    logic signed [INW-1:0]  bias;
    logic                   tap_valid;
    logic                   tap_first;
    logic                   tap_last;
    logic signed [OUTW-1:0] result;
    logic                   result_valid;
    logic                   room;

    conv_input_mems #(.INW(INW), .R(R), .C(C), .MAXK(MAXK)) i_input_mems (
        .clk, .reset,
        .INPUT_TDATA, .INPUT_TUSER, .INPUT_TVALID, .INPUT_TREADY,
        .job_release, .loaded, .k,
        .x_addr, .w_addr, .x_data, .w_data, .bias
    );

    conv_sequencer #(.R(R), .C(C), .MAXK(MAXK)) i_sequencer (
        .clk, .reset, .loaded, .k, .room,
        .job_release, .tap_valid, .tap_first, .tap_last,
        .x_addr, .w_addr
    );

    conv_mac #(.INW(INW), .MAXK(MAXK)) i_mac (
        .clk, .reset, .x_data, .w_data, .bias,
        .tap_valid, .tap_first, .tap_last,
        .result, .result_valid
    );

    conv_out_fifo #(.INW(INW), .MAXK(MAXK), .FIFO_DEPTH(FIFO_DEPTH)) i_out_fifo (
        .clk, .reset, .result, .result_valid, .room,
        .OUTPUT_TDATA, .OUTPUT_TVALID, .OUTPUT_TREADY
    );

endmodule

// ==== tb.f ====
src/conv_pkg.sv
src/conv_input_mems.sv
src/conv_sequencer.sv
src/conv_mac.sv
src/conv_out_fifo.sv
src/conv_top.sv
bench/conv_props.sv
bench/conv_tb.sv
